/* hw/sdmac_pkg.sv */
/* Shared constants for the SDMAC slave core. The register map is word indexed, and
   port timing is counted in sclk cycles. */
package sdmac_pkg;

    localparam int addr_width = 5;  // Word address bits 6:2 of the host bus
    localparam int data_width = 32; // Host data word
    localparam int pd_width   = 16; // Peripheral data bus

    // Register indices in the lower half of the address space
    localparam logic [addr_width-1:0] reg_wtc  = 5'd1; // Word transfer count
    localparam logic [addr_width-1:0] reg_cntr = 5'd2; // Control
    localparam logic [addr_width-1:0] reg_acr  = 5'd3; // Address
    localparam logic [addr_width-1:0] reg_istr = 5'd7; // Interrupt status, read only

    localparam int wtc_width      = 24;
    localparam int cntr_inten_bit = 2;                      // Interrupt enable
    localparam logic [data_width-1:0] cntr_mask = 32'h0000001f; // Writable CNTR bits

    localparam int istr_inta_bit = 0; // Raw SCSI chip line
    localparam int istr_intb_bit = 1; // Raw spare line
    localparam int istr_int_bit  = 4; // Pending, gated by inten

    localparam int port_sel_bit = 4; // High half goes to the peripheral port
    localparam int pd_sel_lsb   = 2; // Select field is addr 3:2

    localparam logic [1:0] pd_sel_css  = 2'd0; // WD33C93
    localparam logic [1:0] pd_sel_csx0 = 2'd1;
    localparam logic [1:0] pd_sel_csx1 = 2'd2; // Code 3 is the empty select

    localparam int pd_cnt_width = 2;
    localparam logic [pd_cnt_width-1:0] pd_setup_cycles  = 2'd1;
    localparam logic [pd_cnt_width-1:0] pd_strobe_cycles = 2'd3; // Minimum, iordy stretches it
    localparam logic [pd_cnt_width-1:0] pd_hold_cycles   = 2'd1;

    // Port phase encoding
    localparam int pd_phase_width = 2;
    localparam logic [pd_phase_width-1:0] pd_idle   = 2'd0;
    localparam logic [pd_phase_width-1:0] pd_setup  = 2'd1;
    localparam logic [pd_phase_width-1:0] pd_strobe = 2'd2;
    localparam logic [pd_phase_width-1:0] pd_hold   = 2'd3;

    localparam int led_cnt_width = 8;
    localparam logic [led_cnt_width-1:0] led_stretch_cycles = 8'd255; // Visible blink

endpackage

/* hw/cpu_bus_if.sv */
/* One host request at a time. The payload stays latched until job_free, so the
   downstream blocks read it directly. */
`timescale 1ns/1ps
module cpu_bus_if (
    input  logic                             sclk,
    input  logic                             rst,
    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic [sdmac_pkg::addr_width-1:0] req_addr,
    input  logic                             req_we,
    input  logic [sdmac_pkg::data_width-1:0] req_wdata,
    input  logic                             job_free,
    output logic [sdmac_pkg::addr_width-1:0] job_addr,
    output logic                             job_we,
    output logic [sdmac_pkg::data_width-1:0] job_wdata,
    output logic                             reg_go,
    output logic                             pd_go
);

    logic busy; // High while a job is in flight
    logic take; // Request handshake

    assign req_ready = !busy;
    assign take      = req_valid && !busy;

    always_ff @(posedge sclk) begin
        if (rst) begin
            busy   <= 1'b0;
            reg_go <= 1'b0;
            pd_go  <= 1'b0;
        end else begin
            reg_go <= 1'b0; // Single cycle pulses
            pd_go  <= 1'b0;
            if (take) begin
                busy   <= 1'b1;
                reg_go <= !req_addr[sdmac_pkg::port_sel_bit]; // Register half
                pd_go  <= req_addr[sdmac_pkg::port_sel_bit];  // Peripheral half
            end else if (job_free) begin
                busy <= 1'b0; // Response taken
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (take) begin
            job_addr  <= req_addr;
            job_we    <= req_we;
            job_wdata <= req_wdata;
        end
    end

    // Exactly one target per job
    a_one_target: assert property (@(posedge sclk) disable iff (rst)
        !(reg_go && pd_go));

endmodule

/* hw/sdmac_regs.sv */
/* Internal SDMAC registers. inta and intb are taken as synchronous to sclk;
   unmapped indices read 0 and ignore writes. */
`timescale 1ns/1ps
module sdmac_regs (
    input  logic                             sclk,
    input  logic                             rst,
    input  logic                             reg_go,
    input  logic [sdmac_pkg::addr_width-1:0] job_addr,
    input  logic                             job_we,
    input  logic [sdmac_pkg::data_width-1:0] job_wdata,
    input  logic                             inta,
    input  logic                             intb,
    output logic                             reg_done,
    output logic [sdmac_pkg::data_width-1:0] reg_rdata,
    output logic                             int_n
);

    logic [sdmac_pkg::wtc_width-1:0]  wtc;  // Transfer count
    logic [sdmac_pkg::data_width-1:0] acr;  // DMA address
    logic [sdmac_pkg::data_width-1:0] cntr; // Control, masked bits only
    logic [sdmac_pkg::data_width-1:0] rd_word;
    logic inta_q;   // Sampled lines for ISTR
    logic intb_q;
    logic int_pend; // Gated interrupt, drives int_n

    always_comb begin
        rd_word = '0; // Unmapped reads as zero
        case (job_addr)
            sdmac_pkg::reg_wtc:  rd_word[sdmac_pkg::wtc_width-1:0] = wtc;
            sdmac_pkg::reg_acr:  rd_word = acr;
            sdmac_pkg::reg_cntr: rd_word = cntr;
            sdmac_pkg::reg_istr: begin
                rd_word[sdmac_pkg::istr_inta_bit] = inta_q;
                rd_word[sdmac_pkg::istr_intb_bit] = intb_q;
                rd_word[sdmac_pkg::istr_int_bit]  = int_pend;
            end
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge sclk) begin
        if (rst) begin
            wtc      <= '0;
            acr      <= '0;
            cntr     <= '0;
            reg_done <= 1'b0;
            inta_q   <= 1'b0;
            intb_q   <= 1'b0;
            int_pend <= 1'b0;
        end else begin
            reg_done <= reg_go; // Fixed one cycle access
            inta_q   <= inta;
            intb_q   <= intb;
            int_pend <= cntr[sdmac_pkg::cntr_inten_bit] && (inta || intb);
            if (reg_go && job_we) begin
                case (job_addr)
                    sdmac_pkg::reg_wtc:  wtc  <= job_wdata[sdmac_pkg::wtc_width-1:0];
                    sdmac_pkg::reg_acr:  acr  <= job_wdata;
                    sdmac_pkg::reg_cntr: cntr <= job_wdata & sdmac_pkg::cntr_mask;
                    default: ; // ISTR and holes are read only
                endcase
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (reg_go) begin
            reg_rdata <= rd_word;
        end
    end

    assign int_n = !int_pend; // Active low, one cycle behind the lines

    // Completion one cycle after go, and go never back to back from the host side
    a_reg_done: assert property (@(posedge sclk) disable iff (rst)
        reg_go |=> reg_done && !reg_go);

endmodule

/* hw/pd_port.sv */
/* Strobed 8/16-bit port for a WD33C93 and two spare selects. Select code 3 runs
   the same phases with no chip select or strobe and reads 0. */
`timescale 1ns/1ps
module pd_port (
    input  logic                             sclk,
    input  logic                             rst,
    input  logic                             pd_go,
    input  logic [sdmac_pkg::addr_width-1:0] job_addr,
    input  logic                             job_we,
    input  logic [sdmac_pkg::data_width-1:0] job_wdata,
    input  logic                             iordy,
    input  logic [sdmac_pkg::pd_width-1:0]   pd_in,
    output logic [sdmac_pkg::pd_width-1:0]   pd_out,
    output logic                             pd_oe,
    output logic                             css_n,
    output logic                             csx0_n,
    output logic                             csx1_n,
    output logic                             ior_n,
    output logic                             iow_n,
    output logic                             pd_done,
    output logic [sdmac_pkg::data_width-1:0] pd_rdata
);

    logic [sdmac_pkg::pd_phase_width-1:0] phase;
    logic [sdmac_pkg::pd_cnt_width-1:0]   cnt;  // Cycles left in phase, minus one
    logic [1:0] sel;
    logic sel_ok;     // Real device selected
    logic active;     // Setup through hold
    logic strobe;
    logic strobe_end; // Last strobe cycle, data sampled here

    assign sel        = job_addr[sdmac_pkg::pd_sel_lsb +: 2];
    assign sel_ok     = (sel == sdmac_pkg::pd_sel_css) || (sel == sdmac_pkg::pd_sel_csx0) ||
                        (sel == sdmac_pkg::pd_sel_csx1);
    assign active     = (phase != sdmac_pkg::pd_idle);
    assign strobe     = (phase == sdmac_pkg::pd_strobe);
    assign strobe_end = strobe && (cnt == '0) && (iordy || !sel_ok); // Empty select skips wait

    always_ff @(posedge sclk) begin
        if (rst) begin
            phase <= sdmac_pkg::pd_idle;
            cnt   <= '0;
        end else begin
            case (phase)
                sdmac_pkg::pd_idle: begin
                    if (pd_go) begin
                        phase <= sdmac_pkg::pd_setup;
                        cnt   <= sdmac_pkg::pd_setup_cycles - 1'b1;
                    end
                end
                sdmac_pkg::pd_setup: begin
                    if (cnt == '0) begin
                        phase <= sdmac_pkg::pd_strobe;
                        cnt   <= sdmac_pkg::pd_strobe_cycles - 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                sdmac_pkg::pd_strobe: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (strobe_end) begin
                        phase <= sdmac_pkg::pd_hold;
                        cnt   <= sdmac_pkg::pd_hold_cycles - 1'b1;
                    end // Else stretched by iordy
                end
                default: begin // Hold
                    if (cnt == '0) begin
                        phase <= sdmac_pkg::pd_idle;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sclk) begin
        if (strobe_end) begin
            if (!sel_ok) begin
                pd_rdata <= '0;
            end else if (sel == sdmac_pkg::pd_sel_css) begin
                pd_rdata <= {{(sdmac_pkg::data_width-8){1'b0}}, pd_in[7:0]}; // Byte wide chip
            end else begin
                pd_rdata <= {{(sdmac_pkg::data_width-sdmac_pkg::pd_width){1'b0}}, pd_in};
            end
        end
    end

    assign pd_done = (phase == sdmac_pkg::pd_hold) && (cnt == '0);

    assign css_n  = !(active && sel == sdmac_pkg::pd_sel_css);
    assign csx0_n = !(active && sel == sdmac_pkg::pd_sel_csx0);
    assign csx1_n = !(active && sel == sdmac_pkg::pd_sel_csx1);
    assign ior_n  = !(strobe && sel_ok && !job_we);
    assign iow_n  = !(strobe && sel_ok && job_we);
    assign pd_oe  = active && sel_ok && job_we; // Driven setup through hold
    assign pd_out = (sel == sdmac_pkg::pd_sel_css) ? {8'h00, job_wdata[7:0]} :
                    job_wdata[sdmac_pkg::pd_width-1:0];

    // One strobe at a time, always inside a chip select
    a_strobe_excl: assert property (@(posedge sclk) disable iff (rst)
        (!ior_n || !iow_n) |-> (ior_n != iow_n) && !(css_n && csx0_n && csx1_n));

endmodule

/* hw/bus_response.sv */
/* Single slot response buffer with LED stretching. Writes answer with rdata 0;
   only one completion can be outstanding. */
`timescale 1ns/1ps
module bus_response (
    input  logic                             sclk,
    input  logic                             rst,
    input  logic                             reg_done,
    input  logic [sdmac_pkg::data_width-1:0] reg_rdata,
    input  logic                             pd_done,
    input  logic [sdmac_pkg::data_width-1:0] pd_rdata,
    input  logic                             job_we,
    output logic                             rsp_valid,
    input  logic                             rsp_ready,
    output logic [sdmac_pkg::data_width-1:0] rsp_rdata,
    output logic                             job_free,
    output logic                             led_rd_n,
    output logic                             led_wr_n
);

    logic done; // Completion from either target
    logic [sdmac_pkg::led_cnt_width-1:0] rd_cnt; // LED hold timers
    logic [sdmac_pkg::led_cnt_width-1:0] wr_cnt;

    assign done     = reg_done || pd_done;
    assign job_free = rsp_valid && rsp_ready; // Response handshake

    always_ff @(posedge sclk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            rd_cnt    <= '0;
            wr_cnt    <= '0;
        end else begin
            if (done) begin
                rsp_valid <= 1'b1;
            end else if (job_free) begin
                rsp_valid <= 1'b0;
            end
            if (done && !job_we) begin
                rd_cnt <= sdmac_pkg::led_stretch_cycles; // Restart
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
            if (done && job_we) begin
                wr_cnt <= sdmac_pkg::led_stretch_cycles;
            end else if (wr_cnt != '0) begin
                wr_cnt <= wr_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (done) begin
            rsp_rdata <= job_we ? '0 : (reg_done ? reg_rdata : pd_rdata);
        end
    end

    assign led_rd_n = (rd_cnt == '0); // Lit while counting
    assign led_wr_n = (wr_cnt == '0);

    // Offered response holds under back-pressure
    a_rsp_hold: assert property (@(posedge sclk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

endmodule

/* hw/resdmac.sv */
/* SDMAC slave core top. No bus mastering or DMA engine; the peripheral data bus
   is split into in, out and output enable for an external tri-state pad. */
`timescale 1ns/1ps
module resdmac (
    input  logic                             sclk,
    input  logic                             rst,
    input  logic                             req_valid,
    output logic                             req_ready,
    input  logic [sdmac_pkg::addr_width-1:0] req_addr,
    input  logic                             req_we,
    input  logic [sdmac_pkg::data_width-1:0] req_wdata,
    output logic                             rsp_valid,
    input  logic                             rsp_ready,
    output logic [sdmac_pkg::data_width-1:0] rsp_rdata,
    input  logic                             inta,   // WD33C93 interrupt
    input  logic                             intb,   // Spare interrupt
    output logic                             int_n,  // Wants open collector at the pin
    input  logic                             iordy,
    input  logic [sdmac_pkg::pd_width-1:0]   pd_in,
    output logic [sdmac_pkg::pd_width-1:0]   pd_out,
    output logic                             pd_oe,
    output logic                             css_n,
    output logic                             csx0_n,
    output logic                             csx1_n,
    output logic                             ior_n,
    output logic                             iow_n,
    output logic                             led_rd_n,
    output logic                             led_wr_n
);

    logic [sdmac_pkg::addr_width-1:0] job_addr;
    logic                             job_we;
    logic [sdmac_pkg::data_width-1:0] job_wdata;
    logic                             job_free;
    logic                             reg_go;
    logic                             pd_go;
    logic                             reg_done;
    logic                             pd_done;
    logic [sdmac_pkg::data_width-1:0] reg_rdata;
    logic [sdmac_pkg::data_width-1:0] pd_rdata;

    cpu_bus_if u_cpu_bus_if (
        .sclk      (sclk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_we    (req_we),
        .req_wdata (req_wdata),
        .job_free  (job_free),
        .job_addr  (job_addr),
        .job_we    (job_we),
        .job_wdata (job_wdata),
        .reg_go    (reg_go),
        .pd_go     (pd_go)
    );

    sdmac_regs u_sdmac_regs (
        .sclk      (sclk),
        .rst       (rst),
        .reg_go    (reg_go),
        .job_addr  (job_addr),
        .job_we    (job_we),
        .job_wdata (job_wdata),
        .inta      (inta),
        .intb      (intb),
        .reg_done  (reg_done),
        .reg_rdata (reg_rdata),
        .int_n     (int_n)
    );

    pd_port u_pd_port (
        .sclk      (sclk),
        .rst       (rst),
        .pd_go     (pd_go),
        .job_addr  (job_addr),
        .job_we    (job_we),
        .job_wdata (job_wdata),
        .iordy     (iordy),
        .pd_in     (pd_in),
        .pd_out    (pd_out),
        .pd_oe     (pd_oe),
        .css_n     (css_n),
        .csx0_n    (csx0_n),
        .csx1_n    (csx1_n),
        .ior_n     (ior_n),
        .iow_n     (iow_n),
        .pd_done   (pd_done),
        .pd_rdata  (pd_rdata)
    );

    bus_response u_bus_response (
        .sclk      (sclk),
        .rst       (rst),
        .reg_done  (reg_done),
        .reg_rdata (reg_rdata),
        .pd_done   (pd_done),
        .pd_rdata  (pd_rdata),
        .job_we    (job_we),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .job_free  (job_free),
        .led_rd_n  (led_rd_n),
        .led_wr_n  (led_wr_n)
    );

endmodule

/* test/tb_tasks.svh */
/* Bus driver and directed tests, included inside tb_resdmac. Tasks start and end
   on a falling edge. */

task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("mismatch %s got %h expected %h", name, got, exp);
    end
endtask

task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
        errors++;
        $display("failure: %s", what);
    end
endtask

// One request and one response handshake with lat counted from the request handshake
task automatic bus_access(input logic [4:0] addr, input logic we, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int lat);
    int          cyc;
    bit          seen;
    bit          taken;
    logic [31:0] held;
    logic [31:0] junk;
    cyc     = 0;
    seen    = 1'b0;
    taken   = 1'b0;
    held    = 32'h0;
    rdata   = 32'h0;
    lat     = 0;
    cs_seen = 3'b000;
    req_valid = 1'b1;
    req_addr  = addr;
    req_we    = we;
    req_wdata = wdata;
    while (!req_ready && cyc < resp_limit) begin
        @(negedge sclk);
        cyc++;
    end
    expect_true(req_ready, "request channel never became ready");
    @(negedge sclk); // Request taken on the edge before
    junk      = $urandom();
    req_valid = stall_en; // Second request offered while busy
    req_addr  = junk[4:0]; // Core must keep its own copy
    req_we    = junk[5];
    req_wdata = junk;
    cyc = 1;
    while (cyc < resp_limit) begin
        cs_seen = cs_seen | ~{csx1_n, csx0_n, css_n};
        if (!iow_n) begin
            expect_true(pd_oe, "pd_oe was low during a write strobe");
            expect_true(css_n || pd_out[15:8] == 8'h00, "upper pd_out byte driven on css");
        end
        expect_true(!req_ready, "a second request could be accepted while busy");
        if (rsp_valid) begin
            if (!seen) begin
                seen = 1'b1;
                lat  = cyc;
                held = rsp_rdata;
            end
            compare_word("rsp_rdata while offered", rsp_rdata, held);
        end
        rsp_ready = stall_en ? ($urandom_range(2, 0) == 0) : 1'b1;
        if (rsp_valid && rsp_ready) begin
            taken = 1'b1;
            break;
        end
        @(negedge sclk);
        cyc++;
    end
    expect_true(taken, "no response within the access limit");
    rdata     = rsp_rdata;
    req_valid = 1'b0;
    @(negedge sclk);
    rsp_ready = 1'b1;
endtask

// exp_lat of 0 skips the latency check
task automatic bus_write(input logic [4:0] addr, input logic [31:0] wdata, input int exp_lat);
    logic [31:0] rdata;
    int          lat;
    bus_access(addr, 1'b1, wdata, rdata, lat);
    compare_word("write rsp_rdata", rdata, 32'h0); // Writes answer with 0
    if (exp_lat != 0) begin
        compare_word("write latency", lat, exp_lat);
    end
endtask

task automatic bus_read(input logic [4:0] addr, output logic [31:0] rdata, input int exp_lat);
    int lat;
    bus_access(addr, 1'b0, 32'h0, rdata, lat);
    if (exp_lat != 0) begin
        compare_word("read latency", lat, exp_lat);
    end
endtask

task automatic reset_state();
    logic [31:0] r;
    // rsp_valid req_ready int_n css_n csx0_n csx1_n ior_n iow_n led_rd_n led_wr_n pd_oe
    compare_word("reset outputs", {21'h0, rsp_valid, req_ready, int_n, css_n, csx0_n, csx1_n,
                 ior_n, iow_n, led_rd_n, led_wr_n, pd_oe}, 32'h0000_03fe);
    for (int i = 0; i < 16; i++) begin
        bus_read({1'b0, i[3:0]}, r, 3);
        compare_word($sformatf("reg %0d after reset", i), r, 32'h0);
    end
    expect_true(!led_rd_n, "read LED dark after reads");
    expect_true(led_wr_n, "write LED lit although no write was made");
endtask

task automatic reg_readback();
    logic [31:0] v;
    logic [31:0] r;
    logic [31:0] acr_val;
    v = $urandom();
    bus_write(sdmac_pkg::reg_wtc, v, 3);
    bus_read(sdmac_pkg::reg_wtc, r, 3);
    compare_word("wtc", r, v & 32'h00ff_ffff); // 24 bit count
    acr_val = $urandom();
    bus_write(sdmac_pkg::reg_acr, acr_val, 3);
    bus_read(sdmac_pkg::reg_acr, r, 3);
    compare_word("acr", r, acr_val);
    v = $urandom();
    bus_write(sdmac_pkg::reg_cntr, v, 3);
    bus_read(sdmac_pkg::reg_cntr, r, 3);
    compare_word("cntr", r, v & 32'h0000_001f);
    bus_write(sdmac_pkg::reg_cntr, 32'h0, 3);
    for (int i = 0; i < 16; i++) begin
        if (i inside {1, 2, 3}) begin
            continue;
        end
        v = $urandom();
        bus_write({1'b0, i[3:0]}, v, 3); // Holes and ISTR ignore writes
        bus_read({1'b0, i[3:0]}, r, 3);
        compare_word($sformatf("reg %0d after write", i), r, 32'h0);
    end
    bus_read(sdmac_pkg::reg_acr, r, 3);
    compare_word("acr after hole writes", r, acr_val);
endtask

task automatic interrupt_gating();
    logic [31:0] r;
    logic [31:0] exp;
    logic        a;
    logic        b;
    logic        pend;
    for (int en = 0; en < 2; en++) begin
        bus_write(sdmac_pkg::reg_cntr, en[0] ? 32'h0000_0004 : 32'h0, 3); // Bit 2 inten
        for (int c = 0; c < 4; c++) begin
            a    = c[0];
            b    = c[1];
            inta = a;
            intb = b;
            repeat (2) @(negedge sclk); // Registered int_n
            pend = en[0] && (a || b);
            compare_word("int_n", {31'h0, int_n}, {31'h0, !pend});
            exp = 32'h0;
            exp[sdmac_pkg::istr_inta_bit] = a;
            exp[sdmac_pkg::istr_intb_bit] = b;
            exp[sdmac_pkg::istr_int_bit]  = pend;
            bus_read(sdmac_pkg::reg_istr, r, 3);
            compare_word("istr", r, exp);
        end
    end
    inta = 1'b0;
    intb = 1'b0;
    bus_write(sdmac_pkg::reg_cntr, 32'h0, 3);
endtask

task automatic port_selects();
    logic [31:0] v;
    logic [31:0] r;
    logic [31:0] exp;
    logic [4:0]  addr;
    logic [1:0]  sel;
    for (int s = 0; s < 4; s++) begin
        sel  = s[1:0];
        addr = {1'b1, sel, 2'b00};
        v    = $urandom();
        bus_write(addr, v, 7);
        compare_word("write chip selects", {29'h0, cs_seen}, {29'h0, 3'b001 << sel});
        exp = (sel == 2'd0) ? {24'h0, v[7:0]} : {16'h0, v[15:0]};
        if (sel != 2'd3) begin
            compare_word("device word", {16'h0, dev_mem[sel]}, exp);
        end
        bus_read(addr, r, 7);
        compare_word("read chip selects", {29'h0, cs_seen}, {29'h0, 3'b001 << sel});
        if (sel == 2'd3) begin
            exp = 32'h0; // Empty select
        end
        compare_word("port rdata", r, exp);
    end
endtask

task automatic waits_and_stalls();
    logic [31:0] v;
    logic [31:0] r;
    logic [31:0] exp;
    logic [4:0]  addr;
    logic [1:0]  sel;
    waits_en = 1'b1;
    stall_en = 1'b1;
    repeat (24) begin
        sel  = 2'($urandom_range(2, 0));
        addr = {1'b1, sel, 2'b00};
        v    = $urandom();
        bus_write(addr, v, 0);
        expect_true(!led_wr_n, "write LED dark after a write");
        bus_read(addr, r, 0);
        exp = (sel == 2'd0) ? {24'h0, v[7:0]} : {16'h0, v[15:0]};
        compare_word("port rdata with waits", r, exp);
        expect_true(!led_rd_n, "read LED dark after a read");
        v = $urandom();
        bus_write(sdmac_pkg::reg_acr, v, 0);
        bus_read(sdmac_pkg::reg_acr, r, 0);
        compare_word("acr under stalls", r, v);
    end
    waits_en = 1'b0;
    stall_en = 1'b0;
endtask

/* test/tb_resdmac.sv */
/* Directed testbench for the SDMAC core. The device model answers on all three selects;
   iordy waits and response stalls are switched on per test. */
`timescale 1ns/1ps
module tb_resdmac;

    localparam int num_tests       = 5;
    localparam int watchdog_cycles = 2000 * num_tests;
    localparam int resp_limit      = 64; // Cycles one access may take, stalls included

    logic        sclk = 1'b0;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    logic [4:0]  req_addr;
    logic        req_we;
    logic [31:0] req_wdata;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_rdata;
    logic        inta;
    logic        intb;
    logic        int_n;
    logic        iordy = 1'b1;      // Driven by the device model
    logic [15:0] pd_in = 16'h0000;
    logic [15:0] pd_out;
    logic        pd_oe;
    logic        css_n;
    logic        csx0_n;
    logic        csx1_n;
    logic        ior_n;
    logic        iow_n;
    logic        led_rd_n;
    logic        led_wr_n;

    int          errors;
    int          checks;
    bit          waits_en;          // Random iordy waits in the model
    bit          stall_en;          // Random rsp_ready back-pressure
    logic [2:0]  cs_seen;           // Selects seen low during the last access, csx1 csx0 css
    logic [15:0] dev_mem [0:3];     // One word per select, entry 3 unused
    logic        strobe_q;
    int          wait_left;

    always #10 sclk = ~sclk; // 20 ns period

    resdmac DUT (
        .sclk      (sclk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_we    (req_we),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .inta      (inta),
        .intb      (intb),
        .int_n     (int_n),
        .iordy     (iordy),
        .pd_in     (pd_in),
        .pd_out    (pd_out),
        .pd_oe     (pd_oe),
        .css_n     (css_n),
        .csx0_n    (csx0_n),
        .csx1_n    (csx1_n),
        .ior_n     (ior_n),
        .iow_n     (iow_n),
        .led_rd_n  (led_rd_n),
        .led_wr_n  (led_wr_n)
    );

    // Device model, works on the falling edge where the port outputs are settled
    always @(negedge sclk) begin
        logic [1:0]  idx;
        logic [31:0] rnd;
        rnd = $urandom();
        idx = !css_n ? 2'd0 : !csx0_n ? 2'd1 : !csx1_n ? 2'd2 : 2'd3;
        if (rst) begin
            for (int k = 0; k < 4; k++) begin
                dev_mem[k[1:0]] = {4'ha, 2'b00, k[1:0], 4'h5, 2'b11, ~k[1:0]}; // Per select fill
            end
            wait_left = 0;
            strobe_q  = 1'b0;
            iordy     = 1'b1;
            pd_in     = rnd[15:0];
        end else begin
            if (!iow_n && idx != 2'd3) begin
                dev_mem[idx] = (idx == 2'd0) ? {8'h00, pd_out[7:0]} : pd_out; // css is 8 bit
            end
            if ((!ior_n || !iow_n) && !strobe_q) begin
                wait_left = waits_en ? int'(rnd[17:16]) : 0; // New strobe, 0 to 3 waits
            end else if (wait_left > 0) begin
                wait_left = wait_left - 1;
            end
            strobe_q = !ior_n || !iow_n;
            iordy    = (wait_left == 0);
            if (!ior_n && idx == 2'd0) begin
                pd_in = {rnd[15:8], dev_mem[0][7:0]}; // Upper lines float on css
            end else if (!ior_n) begin
                pd_in = dev_mem[idx];
            end else begin
                pd_in = rnd[15:0]; // Bus noise between reads
            end
        end
    end

    `include "tb_tasks.svh"

    initial begin
        void'($urandom(32'hcae2207c));
        errors    = 0;
        checks    = 0;
        waits_en  = 1'b0;
        stall_en  = 1'b0;
        cs_seen   = 3'b000;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_addr  = 5'h00;
        req_we    = 1'b0;
        req_wdata = 32'h0;
        rsp_ready = 1'b1;
        inta      = 1'b0;
        intb      = 1'b0;
        repeat (10) @(negedge sclk);
        rst = 1'b0;
        @(negedge sclk);
        reset_state();
        reg_readback();
        interrupt_gating();
        port_selects();
        waits_and_stalls();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge sclk);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("checks %0d errors %0d", checks, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* src.f */
hw/sdmac_pkg.sv
hw/cpu_bus_if.sv
hw/sdmac_regs.sv
hw/pd_port.sv
hw/bus_response.sv
hw/resdmac.sv
+incdir+test
test/tb_resdmac.sv

/* Makefile */
# Verilator build and run of the SDMAC testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a reported error"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
		--top-module tb_resdmac -Mdir obj_dir -o sim_resdmac
	./obj_dir/sim_resdmac | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "test did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
